// ==== freq_consts.svh ====
`ifndef FREQ_CONSTS_SVH
`define FREQ_CONSTS_SVH

// Build-time sizing of the frequency meter

// Measured channels, limited to four by the two-bit channel index
`define FR_NCHAN 4

// Width of one edge count, enough for eight decimal digits
`define FR_CNT_W 27

// Counting window in refclk cycles, short for simulation
`define FR_GATE_CYC 4000

// Decimal digits printed per channel
`define FR_DIGITS 8

// Refclk cycles per UART bit, short for simulation
`define FR_BAUD_DIV 4

`endif

// ==== freq_pkg.sv ====
`default_nettype none

`include "freq_consts.svh"

package freq_pkg;

	// Raw edge count of one channel over one window
	typedef logic [`FR_CNT_W-1:0] count_t;

	// Channel index
	typedef logic [1:0] chan_t;

	// One BCD digit
	typedef logic [3:0] digit_t;

	// Report formatter FSM
	// TEXT sends template characters, DIGITS sends serializer output
	// NEXT steps to the following channel, DONE waits for the last stop bit
	typedef enum logic [2:0] {
		IDLE,
		TEXT,
		DIGITS,
		NEXT,
		DONE
	} fmt_state_t;

endpackage

`default_nettype wire

// ==== gate_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "freq_consts.svh"

module gate_timer (
	input  wire  refclk,
	input  wire  resetn,
	output logic gate,
	output logic load
);

	// Window plus four cycles of dead time
	localparam int PERIOD = `FR_GATE_CYC + 4;
	localparam int TMR_W = $clog2(PERIOD);

	logic [TMR_W-1:0] tmr;
	logic armed;

	// Down-counter over one full period
	// Values above 3 are the window, 3 down to 0 the dead time
	always_ff @(posedge refclk) begin
		if (resetn) begin
			// Start in the dead time so the first window opens after 4 cycles
			tmr <= TMR_W'(3);
			armed <= 1'b0;
		end else begin
			if (tmr == '0)
				tmr <= TMR_W'(PERIOD - 1);
			else
				tmr <= tmr - 1'b1;
			// No result exists before the first window has run
			if (gate)
				armed <= 1'b1;
		end
	end

	assign gate = tmr > TMR_W'(3);

	// One cycle after gate falls
	assign load = armed && (tmr == TMR_W'(2));

	// Every window that closes hands its total to the counters
	assert property (@(posedge refclk) disable iff (resetn)
		$fell(gate) |=> load)
		else $error("window closed without a load");

endmodule

`default_nettype wire

// ==== chan_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module chan_counter
	import freq_pkg::*;
(
	input  wire    refclk,
	input  wire    resetn,
	input  wire    unk_clk,
	input  wire    gate,
	input  wire    load,
	output count_t count
);

	logic sync_a;
	logic sync_b;
	logic sync_q;
	logic gate_q;
	logic rise;
	logic gate_rise;
	count_t run;

	// Two-flop synchronizer plus one flop for edge detection
	// unk_clk must stay below a third of refclk to be seen
	always_ff @(posedge refclk) begin
		if (resetn) begin
			sync_a <= 1'b0;
			sync_b <= 1'b0;
			sync_q <= 1'b0;
			gate_q <= 1'b0;
		end else begin
			sync_a <= unk_clk;
			sync_b <= sync_a;
			sync_q <= sync_b;
			gate_q <= gate;
		end
	end

	assign rise = sync_b & ~sync_q;
	assign gate_rise = gate & ~gate_q;

	// Running total over the window
	always_ff @(posedge refclk) begin
		if (resetn) begin
			run <= '0;
		end else if (gate_rise) begin
			// Fresh window, an edge in its first cycle still counts
			run <= count_t'(rise);
		end else if (gate && rise) begin
			run <= run + 1'b1;
		end
	end

	// Result held for the report until the next load
	always_ff @(posedge refclk) begin
		if (load)
			count <= run;
	end

	// A counted edge inside the window never brings the total back to zero
	assert property (@(posedge refclk) disable iff (resetn)
		(gate && !gate_rise && rise) |=> (run != '0))
		else $error("channel count wrapped");

endmodule

`default_nettype wire

// ==== bcd_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "freq_consts.svh"

module bcd_serializer
	import freq_pkg::*;
(
	input  wire                            refclk,
	input  wire                            resetn,
	input  wire [`FR_NCHAN*`FR_CNT_W-1:0]  counts,
	input  wire                            start,
	input  wire chan_t                     sel,
	output digit_t                         nib,
	output logic                           rts,
	input  wire                            cts
);

	localparam int BCD_W = 4 * `FR_DIGITS;
	localparam int STEP_W = $clog2(`FR_CNT_W + 1);
	localparam int DIG_W = $clog2(`FR_DIGITS + 1);

	count_t bin;
	logic [BCD_W-1:0] bcd;
	logic [BCD_W-1:0] bcd_adj;
	logic [STEP_W-1:0] steps;
	logic [DIG_W-1:0] digs;
	logic conv;

	// Shift-and-add-3 correction
	// Any digit of 5 or more would pass 9 when doubled
	function automatic logic [BCD_W-1:0] add3(input logic [BCD_W-1:0] v);
		logic [BCD_W-1:0] r;
		r = v;
		for (int i = 0; i < `FR_DIGITS; i++) begin
			if (r[4*i +: 4] >= 4'd5)
				r[4*i +: 4] = r[4*i +: 4] + 4'd3;
		end
		return r;
	endfunction

	assign bcd_adj = add3(bcd);

	// Sequencing, conversion first and then digit hand-out
	always_ff @(posedge refclk) begin
		if (resetn) begin
			conv <= 1'b0;
			steps <= '0;
			digs <= '0;
			rts <= 1'b0;
		end else if (start) begin
			conv <= 1'b1;
			steps <= STEP_W'(`FR_CNT_W);
			rts <= 1'b0;
		end else if (conv) begin
			steps <= steps - 1'b1;
			// Last shift lands now, digits are ready next cycle
			if (steps == STEP_W'(1)) begin
				conv <= 1'b0;
				rts <= 1'b1;
				digs <= DIG_W'(`FR_DIGITS);
			end
		end else if (cts) begin
			digs <= digs - 1'b1;
			if (digs == DIG_W'(1))
				rts <= 1'b0;
		end
	end

	// Data path
	always_ff @(posedge refclk) begin
		if (start) begin
			bin <= counts[sel*`FR_CNT_W +: `FR_CNT_W];
			bcd <= '0;
		end else if (conv) begin
			// One binary bit moves into the corrected BCD word per cycle
			{bcd, bin} <= {bcd_adj, bin} << 1;
		end else if (cts) begin
			// Next digit moves up to the output position
			bcd <= bcd << 4;
		end
	end

	// Most significant digit first, leading zeros included
	assign nib = bcd[BCD_W-1 -: 4];

	// The formatter only takes a digit that has been offered
	assert property (@(posedge refclk) disable iff (resetn)
		cts |-> rts && !conv)
		else $error("cts without rts");

endmodule

`default_nettype wire

// ==== report_formatter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "freq_consts.svh"

module report_formatter
	import freq_pkg::*;
(
	input  wire         refclk,
	input  wire         resetn,
	input  wire         load,
	output logic        start,
	output chan_t       sel,
	input  wire digit_t nib,
	input  wire         rts,
	output logic        cts,
	output logic [7:0]  data,
	output logic        we,
	input  wire         busy
);

	// Line is "Ch n: " then the digits then CR LF
	localparam int LINE_LEN = `FR_DIGITS + 8;
	localparam int DIG_FIRST = 6;
	localparam int DIG_LAST = DIG_FIRST + `FR_DIGITS - 1;
	localparam int POS_W = $clog2(LINE_LEN);

	fmt_state_t state;
	chan_t chan;
	logic [POS_W-1:0] pos;
	logic [7:0] text_char;

	// Fixed characters of the template, channel number as ASCII at position 3
	always_comb begin
		case (pos)
			POS_W'(0): text_char = "C";
			POS_W'(1): text_char = "h";
			POS_W'(2): text_char = " ";
			POS_W'(3): text_char = {6'b001100, chan};
			POS_W'(4): text_char = ":";
			POS_W'(5): text_char = " ";
			POS_W'(LINE_LEN - 2): text_char = 8'h0d;
			default: text_char = 8'h0a;
		endcase
	end

	// Conversion kicks off when the template reaches the first digit
	assign start = (state == TEXT) && (pos == POS_W'(DIG_FIRST));
	assign sel = chan;

	// A digit goes out only when offered and the UART is free
	assign cts = (state == DIGITS) && rts && !busy;
	assign we = ((state == TEXT) && !start && !busy) || cts;
	assign data = (state == DIGITS) ? {4'h3, nib} : text_char;

	always_ff @(posedge refclk) begin
		if (resetn) begin
			state <= IDLE;
			chan <= '0;
			pos <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (load) begin
						chan <= '0;
						pos <= '0;
						state <= TEXT;
					end
				end
				TEXT: begin
					if (start) begin
						state <= DIGITS;
					end else if (we) begin
						if (pos == POS_W'(LINE_LEN - 1))
							state <= NEXT;
						else
							pos <= pos + 1'b1;
					end
				end
				DIGITS: begin
					if (cts) begin
						pos <= pos + 1'b1;
						// Back to the template for CR LF
						if (pos == POS_W'(DIG_LAST))
							state <= TEXT;
					end
				end
				NEXT: begin
					if (chan == chan_t'(`FR_NCHAN - 1)) begin
						state <= DONE;
					end else begin
						chan <= chan + 1'b1;
						pos <= '0;
						state <= TEXT;
					end
				end
				DONE: begin
					// Let the final LF leave the UART
					if (!busy)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// A report always finishes before the next window closes
	assert property (@(posedge refclk) disable iff (resetn)
		load |-> state == IDLE)
		else $error("load arrived during a report");

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "freq_consts.svh"

module uart_tx (
	input  wire       refclk,
	input  wire       resetn,
	input  wire [7:0] data,
	input  wire       we,
	output logic      busy,
	output logic      tx
);

	localparam int DIV_W = $clog2(`FR_BAUD_DIV + 1);

	logic [9:0] frame;
	logic [DIV_W-1:0] div;
	logic [3:0] bits;
	logic tick;

	// End of one bit time
	assign tick = busy && (div == '0);

	always_ff @(posedge refclk) begin
		if (resetn) begin
			// All ones keeps the line at idle
			frame <= '1;
			div <= '0;
			bits <= '0;
			busy <= 1'b0;
		end else if (we && !busy) begin
			// Stop bit, data LSB first, start bit at the bottom
			frame <= {1'b1, data, 1'b0};
			div <= DIV_W'(`FR_BAUD_DIV - 1);
			bits <= 4'd10;
			busy <= 1'b1;
		end else if (tick) begin
			frame <= {1'b1, frame[9:1]};
			div <= DIV_W'(`FR_BAUD_DIV - 1);
			bits <= bits - 1'b1;
			// Stop bit has had its full time
			if (bits == 4'd1)
				busy <= 1'b0;
		end else if (busy) begin
			div <= div - 1'b1;
		end
	end

	assign tx = frame[0];

	// Writer waits for the previous frame
	assert property (@(posedge refclk) disable iff (resetn)
		we |-> !busy)
		else $error("write while UART busy");

endmodule

`default_nettype wire

// ==== freq_report_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "freq_consts.svh"

module freq_report_top
	import freq_pkg::*;
(
	input  wire                 refclk,
	input  wire                 resetn,
	input  wire [`FR_NCHAN-1:0] unk_clk,
	output wire                 tx
);

	wire gate;
	wire load;
	wire [`FR_NCHAN*`FR_CNT_W-1:0] counts;
	wire start;
	chan_t sel;
	digit_t nib;
	wire rts;
	wire cts;
	wire [7:0] data;
	wire we;
	wire busy;

	// Common window for all channels
	gate_timer u_gate (
		.refclk (refclk),
		.resetn (resetn),
		.gate   (gate),
		.load   (load)
	);

	// One counter per unknown clock, channel 0 in the low bits
	genvar i;
	generate
		for (i = 0; i < `FR_NCHAN; i++) begin : g_chan
			chan_counter u_cnt (
				.refclk  (refclk),
				.resetn  (resetn),
				.unk_clk (unk_clk[i]),
				.gate    (gate),
				.load    (load),
				.count   (counts[i*`FR_CNT_W +: `FR_CNT_W])
			);
		end
	endgenerate

	bcd_serializer u_bcd (
		.refclk (refclk),
		.resetn (resetn),
		.counts (counts),
		.start  (start),
		.sel    (sel),
		.nib    (nib),
		.rts    (rts),
		.cts    (cts)
	);

	report_formatter u_fmt (
		.refclk (refclk),
		.resetn (resetn),
		.load   (load),
		.start  (start),
		.sel    (sel),
		.nib    (nib),
		.rts    (rts),
		.cts    (cts),
		.data   (data),
		.we     (we),
		.busy   (busy)
	);

	uart_tx u_uart (
		.refclk (refclk),
		.resetn (resetn),
		.data   (data),
		.we     (we),
		.busy   (busy),
		.tx     (tx)
	);

endmodule

`default_nettype wire

// ==== tb_freq_report.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "freq_consts.svh"

module tb_freq_report;

	localparam int REF_PER_NS = 4;
	localparam int RESET_CYC = 8;
	localparam int PERIOD_CYC = `FR_GATE_CYC + 4;
	localparam int LINE_LEN = `FR_DIGITS + 8;
	localparam int DIG_FIRST = 6;
	localparam int NUM_REPORTS = 3;
	localparam int ASCII_ZERO = 48;
	// Slowest channel prints at most three significant digits
	localparam int SLOW_CHAN = 3;
	localparam int SLOW_ZEROS = 5;
	// Four gate periods plus twenty percent
	localparam longint WATCHDOG_NS = longint'(4 * PERIOD_CYC * REF_PER_NS) * 6 / 5;

	logic refclk = 1'b0;
	logic resetn;
	wire [`FR_NCHAN-1:0] unk_clk;
	wire tx;

	int n_checks = 0;
	int n_errors = 0;
	int n_reports = 0;

	// Received characters and the time their start bit was seen
	logic [7:0] rx_q[$];
	time rx_t[$];

	real phase_ns[`FR_NCHAN];
	logic phases_ready = 1'b0;

	freq_report_top UUT (
		.refclk  (refclk),
		.resetn  (resetn),
		.unk_clk (unk_clk),
		.tx      (tx)
	);

	always #(REF_PER_NS / 2.0) refclk = ~refclk;

	// Periods of the unknown clocks in ns
	function automatic int clk_period_ns(input int c);
		case (c)
			0: return 12;
			1: return 17;
			2: return 26;
			default: return 40;
		endcase
	endfunction

	// Edges of one unknown clock that fit into the counting window
	function automatic longint expected_count(input int period_ns);
		return longint'(`FR_GATE_CYC * REF_PER_NS / period_ns);
	endfunction

	// Fixed characters of a report line
	function automatic logic [7:0] template_char(input int ch, input int p);
		case (p)
			0: return "C";
			1: return "h";
			2: return " ";
			3: return 8'(ASCII_ZERO + ch);
			4: return ":";
			5: return " ";
			LINE_LEN - 2: return 8'h0d;
			default: return 8'h0a;
		endcase
	endfunction

	function automatic logic is_digit(input logic [7:0] c);
		return (c >= "0") && (c <= "9");
	endfunction

	task automatic check_value(input string name, input longint got, input longint exp,
		input longint tol);
		longint diff;
		n_checks++;
		diff = (got > exp) ? got - exp : exp - got;
		if (diff > tol) begin
			n_errors++;
			$display("CHECK FAILED at %0t ns: %s = %0d, expected %0d (tolerance %0d)",
				$time, name, got, exp, tol);
		end
	endtask

	// Blocks until the UART model has a character
	task automatic next_char(output logic [7:0] c, output time t);
		while (rx_q.size() == 0)
			@(negedge refclk);
		c = rx_q.pop_front();
		t = rx_t.pop_front();
	endtask

	// Channel clocks, each with its own random start phase
	genvar gc;
	generate
		for (gc = 0; gc < `FR_NCHAN; gc++) begin : g_unk
			logic ck = 1'b0;
			logic running = 1'b0;
			assign unk_clk[gc] = ck;
			initial begin
				wait (phases_ready);
				#(phase_ns[gc]);
				running = 1'b1;
			end
			always begin
				wait (running);
				#(clk_period_ns(gc) / 2.0) ck = ~ck;
			end
		end
	endgenerate

	// Seed, phases and reset
	initial begin : stimulus
		int unsigned seed;
		resetn = 1'b1;
		seed = $urandom(81910);
		for (int c = 0; c < `FR_NCHAN; c++)
			phase_ns[c] = real'($urandom % (clk_period_ns(c) * 1000)) / 1000.0;
		phases_ready = 1'b1;
		repeat (RESET_CYC) @(negedge refclk);
		resetn = 1'b0;
	end

	// Line must stay idle through reset and the first window
	initial begin : idle_monitor
		repeat (RESET_CYC + 4 + `FR_GATE_CYC) begin
			@(negedge refclk);
			check_value("tx idle", longint'(tx), 1, 0);
		end
	end

	// UART receiver model in refclk steps
	// Every sample inside a bit must match, the middle one is taken
	initial begin : uart_rx_model
		logic [9:0] frame;
		logic first;
		logic sample;
		time t_start;
		forever begin
			@(negedge refclk);
			if (tx === 1'b0) begin
				t_start = $time;
				for (int b = 0; b < 10; b++) begin
					for (int s = 0; s < `FR_BAUD_DIV; s++) begin
						if (b != 0 || s != 0)
							@(negedge refclk);
						sample = tx;
						if (s == 0)
							first = sample;
						else
							check_value("tx bit stable", longint'(sample), longint'(first), 0);
						if (s == `FR_BAUD_DIV / 2)
							frame[b] = sample;
					end
				end
				check_value("start bit", longint'(frame[0]), 0, 0);
				check_value("stop bit", longint'(frame[9]), 1, 0);
				rx_q.push_back(frame[8:1]);
				rx_t.push_back(t_start);
			end
		end
	end

	// Parses each report line and compares it with the expected text and count
	initial begin : compare
		longint counts [NUM_REPORTS][`FR_NCHAN];
		time first_t [NUM_REPORTS];
		logic [7:0] c;
		time t;
		longint val;
		for (int r = 0; r < NUM_REPORTS; r++) begin
			for (int ch = 0; ch < `FR_NCHAN; ch++) begin
				val = 0;
				for (int p = 0; p < LINE_LEN; p++) begin
					next_char(c, t);
					if (ch == 0 && p == 0)
						first_t[r] = t;
					if (p >= DIG_FIRST && p < DIG_FIRST + `FR_DIGITS) begin
						check_value($sformatf("line %0d char %0d is digit", ch, p),
							longint'(is_digit(c)), 1, 0);
						val = val * 10 + longint'(c) - ASCII_ZERO;
						// Leading zeros stay in the text
						if (ch == SLOW_CHAN && p < DIG_FIRST + SLOW_ZEROS)
							check_value("leading zero", longint'(c), ASCII_ZERO, 0);
					end else begin
						check_value($sformatf("line %0d char %0d", ch, p), longint'(c),
							longint'(template_char(ch, p)), 0);
					end
				end
				counts[r][ch] = val;
				check_value($sformatf("ch%0d count", ch), val,
					expected_count(clk_period_ns(ch)), 1)
				;
			end
			n_reports++;
			// An extra or missing line would shift the report start
			if (r > 0)
				check_value("report spacing ns", longint'(first_t[r] - first_t[r-1]),
					longint'(PERIOD_CYC * REF_PER_NS), 0);
		end
		// Second and third windows agree, so the total clears every window
		for (int ch = 0; ch < `FR_NCHAN; ch++)
			check_value($sformatf("ch%0d repeat", ch), counts[2][ch], counts[1][ch], 1);
		$display("Reports: %0d  Checks: %0d  Errors: %0d", n_reports, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_NS);
		$display("Timeout: only %0d of %0d reports arrived before the watchdog expired",
			n_reports, NUM_REPORTS);
		$display("Reports: %0d  Checks: %0d  Errors: %0d", n_reports, n_checks,
			n_errors + 1);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+.
freq_pkg.sv
gate_timer.sv
chan_counter.sv
bcd_serializer.sv
report_formatter.sv
uart_tx.sv
freq_report_top.sv
tb_freq_report.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_freq_report
FILELIST  ?= vlog.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir
